// ==== hw/BranchPredictor.sv ====
/*
 * Branch predictor top level.
 * Sets the sizes and joins the gshare core and the BTB to fetch and execute.
 */
module BranchPredictor #(
    parameter int FETCH_WIDTH = 2,
    parameter int ISSUE_WIDTH = 2,
    parameter int PHT_ENTRY_NUM = 256,
    parameter int HISTORY_WIDTH = 6,
    parameter int QUEUE_SIZE = 4,
    parameter int BTB_ENTRY_NUM = 16
) (
    input  logic clk,
    input  logic arstN,
    input  logic fetchValid,
    input  GsharePkg::AddrPath fetchPc,
    input  logic resValid[ISSUE_WIDTH],
    input  GsharePkg::AddrPath resAddr[ISSUE_WIDTH],
    input  logic [HISTORY_WIDTH-1:0] resHistory[ISSUE_WIDTH],
    input  GsharePkg::PhtCounter resPhtValue[ISSUE_WIDTH],
    input  logic resTaken[ISSUE_WIDTH],
    input  logic resMispred[ISSUE_WIDTH],
    input  logic resIsCondBr[ISSUE_WIDTH],
    input  GsharePkg::AddrPath resTarget[ISSUE_WIDTH],
    output logic btbHit[FETCH_WIDTH],
    output GsharePkg::AddrPath target[FETCH_WIDTH],
    output logic isCondBr[FETCH_WIDTH],
    output logic predTaken[FETCH_WIDTH],
    output GsharePkg::PhtCounter phtValue[FETCH_WIDTH],
    output logic [HISTORY_WIDTH-1:0] history,
    output logic ready
);

    Gshare #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .ISSUE_WIDTH(ISSUE_WIDTH),
        .PHT_ENTRY_NUM(PHT_ENTRY_NUM),
        .HISTORY_WIDTH(HISTORY_WIDTH),
        .QUEUE_SIZE(QUEUE_SIZE)
    ) gshare (
        .clk(clk),
        .arstN(arstN),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .btbHit(btbHit),
        .isCondBr(isCondBr),
        .resValid(resValid),
        .resAddr(resAddr),
        .resHistory(resHistory),
        .resPhtValue(resPhtValue),
        .resTaken(resTaken),
        .resMispred(resMispred),
        .resIsCondBr(resIsCondBr),
        .predTaken(predTaken),
        .phtValue(phtValue),
        .history(history),
        .ready(ready)
    );

    Btb #(
        .ENTRY_NUM(BTB_ENTRY_NUM),
        .FETCH_WIDTH(FETCH_WIDTH),
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) btb (
        .clk(clk),
        .arstN(arstN),
        .fetchPc(fetchPc),
        .resValid(resValid),
        .resTaken(resTaken),
        .resAddr(resAddr),
        .resTarget(resTarget),
        .resIsCondBr(resIsCondBr),
        .btbHit(btbHit),
        .target(target),
        .isCondBr(isCondBr)
    );

endmodule

// ==== hw/Btb.sv ====
/*
 * Direct-mapped branch target buffer.
 * Looked up once per fetch slot with a one-cycle registered result,
 * and filled by the lowest taken branch result of each cycle.
 */
module Btb #(
    parameter int ENTRY_NUM = 16,
    parameter int FETCH_WIDTH = 2,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic clk,
    input  logic arstN,
    input  GsharePkg::AddrPath fetchPc,
    input  logic resValid[ISSUE_WIDTH],
    input  logic resTaken[ISSUE_WIDTH],
    input  GsharePkg::AddrPath resAddr[ISSUE_WIDTH],
    input  GsharePkg::AddrPath resTarget[ISSUE_WIDTH],
    input  logic resIsCondBr[ISSUE_WIDTH],
    output logic btbHit[FETCH_WIDTH],
    output GsharePkg::AddrPath target[FETCH_WIDTH],
    output logic isCondBr[FETCH_WIDTH]
);
    import GsharePkg::*;

    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);
    localparam int TAG_SHIFT = INDEX_WIDTH + INSN_ADDR_BIT_WIDTH;

    // Entry valid bits, cleared by reset.
    logic entryValid[ENTRY_NUM];
    BtbEntry entryMem[ENTRY_NUM];

    logic [INDEX_WIDTH-1:0] readIndex[FETCH_WIDTH];
    BtbTag readTag[FETCH_WIDTH];
    BtbEntry lookup[FETCH_WIDTH];
    AddrPath slotPc;

    logic writeEn;
    logic [INDEX_WIDTH-1:0] writeIndex;
    BtbEntry writeEntry;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slotPc = fetchPc + AddrPath'(i * INSN_BYTE_WIDTH);
            readIndex[i] = slotPc[TAG_SHIFT-1:INSN_ADDR_BIT_WIDTH];
            readTag[i] = BtbTag'(slotPc >> TAG_SHIFT);
            lookup[i] = entryMem[readIndex[i]];
            lookup[i].valid = entryValid[readIndex[i]];
        end
    end

    // First taken lane fills its entry.
    always_comb begin
        writeEn = 1'b0;
        writeIndex = '0;
        writeEntry = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (!writeEn && resValid[i] && resTaken[i]) begin
                writeEn = 1'b1;
                writeIndex = resAddr[i][TAG_SHIFT-1:INSN_ADDR_BIT_WIDTH];
                writeEntry.valid = 1'b1;
                writeEntry.tag = BtbTag'(resAddr[i] >> TAG_SHIFT);
                writeEntry.target = resTarget[i];
                writeEntry.isCondBr = resIsCondBr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int e = 0; e < ENTRY_NUM; e++) begin
                entryValid[e] <= 1'b0;
            end
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                btbHit[i] <= 1'b0;
            end
        end else begin
            if (writeEn) begin
                entryValid[writeIndex] <= 1'b1;
            end
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                btbHit[i] <= lookup[i].valid && (lookup[i].tag == readTag[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            entryMem[writeIndex] <= writeEntry;
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            target[i] <= lookup[i].target;
            isCondBr[i] <= lookup[i].isCondBr;
        end
    end

endmodule

// ==== hw/Gshare.sv ====
/*
 * Gshare direction predictor core.
 * Holds the global history, reads the PHT per fetch slot, trains counters
 * from execute results through a small write queue, and fills the PHT
 * with weakly-taken counters after reset before raising ready.
 */
module Gshare #(
    parameter int FETCH_WIDTH = 2,
    parameter int ISSUE_WIDTH = 2,
    parameter int PHT_ENTRY_NUM = 256,
    parameter int HISTORY_WIDTH = 6,
    parameter int QUEUE_SIZE = 4
) (
    input  logic clk,
    input  logic arstN,
    input  logic fetchValid,
    input  GsharePkg::AddrPath fetchPc,
    input  logic btbHit[FETCH_WIDTH],
    input  logic isCondBr[FETCH_WIDTH],
    input  logic resValid[ISSUE_WIDTH],
    input  GsharePkg::AddrPath resAddr[ISSUE_WIDTH],
    input  logic [HISTORY_WIDTH-1:0] resHistory[ISSUE_WIDTH],
    input  GsharePkg::PhtCounter resPhtValue[ISSUE_WIDTH],
    input  logic resTaken[ISSUE_WIDTH],
    input  logic resMispred[ISSUE_WIDTH],
    input  logic resIsCondBr[ISSUE_WIDTH],
    output logic predTaken[FETCH_WIDTH],
    output GsharePkg::PhtCounter phtValue[FETCH_WIDTH],
    output logic [HISTORY_WIDTH-1:0] history,
    output logic ready
);
    import GsharePkg::*;

    localparam int INDEX_WIDTH = $clog2(PHT_ENTRY_NUM);
    localparam int PTR_WIDTH = $clog2(QUEUE_SIZE);

    function automatic logic [INDEX_WIDTH-1:0] hashIndex(
        input AddrPath pc,
        input logic [HISTORY_WIDTH-1:0] hist
    );
        logic [31:0] fullIndex;
        fullIndex = phtIndex(pc, 32'(hist), INDEX_WIDTH, HISTORY_WIDTH);
        return fullIndex[INDEX_WIDTH-1:0];
    endfunction

    function automatic PhtCounter trainCounter(input PhtCounter value, input logic taken);
        if (taken) begin
            return (value == PHT_COUNTER_MAX) ? value : value + 1'b1;
        end
        return (value == '0) ? value : value - 1'b1;
    endfunction

    logic phtWe;
    logic [INDEX_WIDTH-1:0] phtWa;
    PhtCounter phtWv;
    logic [INDEX_WIDTH-1:0] phtRa[FETCH_WIDTH];

    logic [HISTORY_WIDTH-1:0] nextHistory;
    logic outValid;
    logic mispredLast;
    logic mispredNow;
    logic [INDEX_WIDTH-1:0] initIndex;

    // Deferred counter writes.
    logic [INDEX_WIDTH-1:0] queueIndex[QUEUE_SIZE];
    PhtCounter queueValue[QUEUE_SIZE];
    logic push;
    logic pop;
    logic full;
    logic empty;
    logic [PTR_WIDTH-1:0] headPtr;
    logic [PTR_WIDTH-1:0] tailPtr;
    logic [INDEX_WIDTH-1:0] pushIndex;
    PhtCounter pushValue;

    PhtRam #(
        .ENTRY_NUM(PHT_ENTRY_NUM),
        .READ_NUM(FETCH_WIDTH)
    ) pht (
        .clk(clk),
        .we(phtWe),
        .wa(phtWa),
        .wv(phtWv),
        .ra(phtRa),
        .rv(phtValue)
    );

    QueuePointer #(
        .SIZE(QUEUE_SIZE)
    ) phtQueuePointer (
        .clk(clk),
        .arstN(arstN),
        .push(push),
        .pop(pop),
        .full(full),
        .empty(empty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

    // Prediction, history update and the next lookup address.
    always_comb begin
        logic scanning;
        scanning = outValid && !mispredLast;
        nextHistory = history;
        mispredNow = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            predTaken[i] = outValid && btbHit[i] && (phtValue[i][1] || !isCondBr[i]);
            if (scanning && btbHit[i]) begin
                if (isCondBr[i]) begin
                    nextHistory = {nextHistory[HISTORY_WIDTH-2:0], predTaken[i]};
                end
                // Nothing after the first hit slot is on the predicted path.
                scanning = 1'b0;
            end
        end
        // Repair from execute; the last mispredicted lane wins.
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (ready && resValid[i] && resMispred[i]) begin
                mispredNow = 1'b1;
                if (resIsCondBr[i]) begin
                    nextHistory = {resHistory[i][HISTORY_WIDTH-2:0], resTaken[i]};
                end else begin
                    nextHistory = resHistory[i];
                end
            end
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            phtRa[i] = hashIndex(fetchPc + AddrPath'(i * INSN_BYTE_WIDTH), nextHistory);
        end
    end

    // Single write port shared by init, direct training and the queue.
    always_comb begin
        phtWe = 1'b0;
        phtWa = '0;
        phtWv = PHT_COUNTER_INIT;
        push = 1'b0;
        pop = 1'b0;
        pushIndex = '0;
        pushValue = '0;
        if (!ready) begin
            phtWe = 1'b1;
            phtWa = initIndex;
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (resValid[i]) begin
                    if (!phtWe) begin
                        phtWe = 1'b1;
                        phtWa = hashIndex(resAddr[i], resHistory[i]);
                        phtWv = trainCounter(resPhtValue[i], resTaken[i]);
                    end else begin
                        push = 1'b1;
                        pushIndex = hashIndex(resAddr[i], resHistory[i]);
                        pushValue = trainCounter(resPhtValue[i], resTaken[i]);
                    end
                end
            end
            if (!phtWe && !empty) begin
                pop = 1'b1;
                phtWe = 1'b1;
                phtWa = queueIndex[headPtr];
                phtWv = queueValue[headPtr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            queueIndex[tailPtr] <= pushIndex;
            queueValue[tailPtr] <= pushValue;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            history <= '0;
            outValid <= 1'b0;
            mispredLast <= 1'b0;
            initIndex <= '0;
            ready <= 1'b0;
        end else begin
            history <= nextHistory;
            outValid <= fetchValid && ready;
            mispredLast <= mispredNow;
            if (!ready) begin
                initIndex <= initIndex + 1'b1;
                // Last entry written this cycle.
                if (initIndex == INDEX_WIDTH'(PHT_ENTRY_NUM - 1)) begin
                    ready <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/GsharePkg.sv ====
/*
 * Shared widths, entry types and the PHT index hash for the gshare predictor.
 * Modules import this package inside their bodies and use scoped names in ports.
 */
package GsharePkg;

    localparam int ADDR_WIDTH = 32;

    // Instruction address and the byte offset below the word address.
    typedef logic [ADDR_WIDTH-1:0] AddrPath;
    localparam int INSN_ADDR_BIT_WIDTH = 2;
    localparam int INSN_BYTE_WIDTH = 4;

    // 2-bit saturating counter, MSB set means taken.
    typedef logic [1:0] PhtCounter;
    localparam PhtCounter PHT_COUNTER_MAX = 2'd3;
    localparam PhtCounter PHT_COUNTER_INIT = 2'd2;

    // Sized for the smallest BTB, so every table fits.
    typedef logic [ADDR_WIDTH-INSN_ADDR_BIT_WIDTH-1:0] BtbTag;

    typedef struct packed {
        logic valid;
        BtbTag tag;
        AddrPath target;
        logic isCondBr;
    } BtbEntry;

    // Word address truncated to the index width.
    // The history is folded into the top bits of the index.
    function automatic logic [31:0] phtIndex(
        input AddrPath pc,
        input logic [31:0] history,
        input int indexWidth,
        input int historyWidth
    );
        logic [31:0] index;
        logic [31:0] histMask;
        index = (pc >> INSN_ADDR_BIT_WIDTH) & ((32'd1 << indexWidth) - 32'd1);
        histMask = (32'd1 << historyWidth) - 32'd1;
        index = index ^ ((history & histMask) << (indexWidth - historyWidth));
        return index;
    endfunction

endpackage

// ==== hw/PhtRam.sv ====
/*
 * Pattern history table storage.
 * Every read port registers its counter each cycle; one write port.
 * A read in the same cycle as a write to that entry returns the old value.
 */
module PhtRam #(
    parameter int ENTRY_NUM = 256,
    parameter int READ_NUM = 2
) (
    input  logic clk,
    input  logic we,
    input  logic [$clog2(ENTRY_NUM)-1:0] wa,
    input  GsharePkg::PhtCounter wv,
    input  logic [$clog2(ENTRY_NUM)-1:0] ra[READ_NUM],
    output GsharePkg::PhtCounter rv[READ_NUM]
);
    import GsharePkg::*;

    PhtCounter mem[ENTRY_NUM];

    // Nonblocking update keeps the read-before-write order.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wv;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] <= mem[ra[i]];
        end
    end

endmodule

// ==== hw/QueuePointer.sv ====
/*
 * Head and tail pointers of a circular queue with full and empty flags.
 * Push when full and pop when empty have no effect.
 */
module QueuePointer #(
    parameter int SIZE = 4
) (
    input  logic clk,
    input  logic arstN,
    input  logic push,
    input  logic pop,
    output logic full,
    output logic empty,
    output logic [$clog2(SIZE)-1:0] headPtr,
    output logic [$clog2(SIZE)-1:0] tailPtr
);
    localparam int PTR_WIDTH = $clog2(SIZE);
    localparam int COUNT_WIDTH = $clog2(SIZE + 1);

    logic [COUNT_WIDTH-1:0] count;
    logic doPush;
    logic doPop;

    assign full = (count == COUNT_WIDTH'(SIZE));
    assign empty = (count == '0);
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= (tailPtr == PTR_WIDTH'(SIZE - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= (headPtr == PTR_WIDTH'(SIZE - 1)) ? '0 : headPtr + 1'b1;
            end
            count <= count + COUNT_WIDTH'(doPush) - COUNT_WIDTH'(doPop);
        end
    end

endmodule

// ==== project.f ====
+incdir+tb
hw/GsharePkg.sv
hw/PhtRam.sv
hw/QueuePointer.sv
hw/Btb.sv
hw/Gshare.sv
hw/BranchPredictor.sv
tb/GshareTb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the testbench with Verilator and runs it; passes only on the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/100ps --top-module GshareTb -f project.f &&
    ./obj_dir/VGshareTb | tee /dev/stderr | grep -qx "Done: no errors" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// ==== tb/GshareModel.svh ====
/*
 * Reference model of the branch predictor, included into the testbench body.
 * stepModel advances it by one rising clock edge from the inputs now driven.
 */
`ifndef GSHARE_MODEL_SVH
`define GSHARE_MODEL_SVH

PhtCounter mPht[PHT_ENTRY_NUM];
logic mBtbValid[BTB_ENTRY_NUM] = '{default: 1'b0};
AddrPath mBtbTag[BTB_ENTRY_NUM];
AddrPath mBtbTarget[BTB_ENTRY_NUM];
logic mBtbCond[BTB_ENTRY_NUM];
logic [HISTORY_WIDTH-1:0] mHistory = '0;
logic mOutValid = 1'b0;
logic mMispredLast = 1'b0;
logic mReady = 1'b0;
int mInitIndex = 0;
int mQueueIndex[$];
PhtCounter mQueueValue[$];
int dropCount = 0;

// Registered lookup results as seen on the outputs.
logic mHit[FETCH_WIDTH] = '{default: 1'b0};
AddrPath mTarget[FETCH_WIDTH];
logic mCond[FETCH_WIDTH];
PhtCounter mPhtOut[FETCH_WIDTH];
AddrPath mFetchPc = '0;

// Word address in the low bits, history folded into the top bits.
function automatic int modelPhtIndex(input AddrPath pc, input logic [HISTORY_WIDTH-1:0] hist);
    int word;
    word = int'(pc[PHT_INDEX_BITS+INSN_ADDR_BIT_WIDTH-1:INSN_ADDR_BIT_WIDTH]);
    return word ^ (int'(hist) << (PHT_INDEX_BITS - HISTORY_WIDTH));
endfunction

function automatic int modelBtbIndex(input AddrPath pc);
    return int'(pc[BTB_INDEX_BITS+INSN_ADDR_BIT_WIDTH-1:INSN_ADDR_BIT_WIDTH]);
endfunction

function automatic AddrPath modelBtbTag(input AddrPath pc);
    return pc >> (BTB_INDEX_BITS + INSN_ADDR_BIT_WIDTH);
endfunction

// Saturating step toward the resolved direction.
function automatic PhtCounter modelTrain(input PhtCounter value, input logic taken);
    if (taken && value != PHT_COUNTER_MAX) begin
        return value + 2'd1;
    end
    if (!taken && value != 2'd0) begin
        return value - 2'd1;
    end
    return value;
endfunction

function automatic logic modelPredTaken(input int slot);
    return mOutValid && mHit[slot] && (mPhtOut[slot][1] || !mCond[slot]);
endfunction

task automatic stepModel();
    logic [HISTORY_WIDTH-1:0] nextHist;
    logic scan;
    logic mispredNow;
    logic phtWe;
    int phtWa;
    PhtCounter phtWv;
    logic pushEn;
    int pushIndex;
    PhtCounter pushValue;
    logic btbWe;
    int btbLane;
    int b;
    AddrPath slotPc;
    nextHist = mHistory;
    scan = mOutValid && !mMispredLast;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
        if (scan && mHit[i]) begin
            if (mCond[i]) begin
                nextHist = {nextHist[HISTORY_WIDTH-2:0], modelPredTaken(i)};
            end
            scan = 1'b0;
        end
    end
    mispredNow = 1'b0;
    phtWe = !mReady;
    phtWa = mInitIndex;
    phtWv = PHT_COUNTER_INIT;
    pushEn = 1'b0;
    pushIndex = 0;
    pushValue = '0;
    btbWe = 1'b0;
    btbLane = 0;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (mReady && resValid[l]) begin
            if (resMispred[l]) begin
                mispredNow = 1'b1;
                nextHist = resIsCondBr[l] ? {resHistory[l][HISTORY_WIDTH-2:0], resTaken[l]}
                                          : resHistory[l];
            end
            if (!phtWe) begin
                phtWe = 1'b1;
                phtWa = modelPhtIndex(resAddr[l], resHistory[l]);
                phtWv = modelTrain(resPhtValue[l], resTaken[l]);
            end else begin
                pushEn = 1'b1;
                pushIndex = modelPhtIndex(resAddr[l], resHistory[l]);
                pushValue = modelTrain(resPhtValue[l], resTaken[l]);
            end
            if (!btbWe && resTaken[l]) begin
                btbWe = 1'b1;
                btbLane = l;
            end
        end
    end
    // Queue drains only into a free write port.
    if (mReady && !phtWe && mQueueIndex.size() > 0) begin
        phtWe = 1'b1;
        phtWa = mQueueIndex.pop_front();
        phtWv = mQueueValue.pop_front();
    end
    if (pushEn) begin
        if (mQueueIndex.size() < QUEUE_SIZE) begin
            mQueueIndex.push_back(pushIndex);
            mQueueValue.push_back(pushValue);
        end else begin
            dropCount++;
        end
    end
    // Reads see the tables before this edge's writes.
    for (int i = 0; i < FETCH_WIDTH; i++) begin
        slotPc = fetchPc + AddrPath'(i * INSN_BYTE_WIDTH);
        b = modelBtbIndex(slotPc);
        mPhtOut[i] = mPht[modelPhtIndex(slotPc, nextHist)];
        mHit[i] = mBtbValid[b] && (mBtbTag[b] == modelBtbTag(slotPc));
        mTarget[i] = mBtbTarget[b];
        mCond[i] = mBtbCond[b];
    end
    if (phtWe) begin
        mPht[phtWa] = phtWv;
    end
    if (btbWe) begin
        b = modelBtbIndex(resAddr[btbLane]);
        mBtbValid[b] = 1'b1;
        mBtbTag[b] = modelBtbTag(resAddr[btbLane]);
        mBtbTarget[b] = resTarget[btbLane];
        mBtbCond[b] = resIsCondBr[btbLane];
    end
    mHistory = nextHist;
    mOutValid = fetchValid && mReady;
    mMispredLast = mispredNow;
    mFetchPc = fetchPc;
    if (!mReady) begin
        if (mInitIndex == PHT_ENTRY_NUM - 1) begin
            mReady = 1'b1;
        end
        mInitIndex++;
    end
endtask

`endif

// ==== tb/GshareTb.sv ====
/*
 * Testbench for the branch predictor top level.
 * Random fetch and result traffic from an LCG is checked every cycle
 * against the included reference model; results replay recorded predictions.
 */
module GshareTb;
    timeunit 1ns;
    timeprecision 100ps;
    import GsharePkg::*;

    localparam int FETCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;
    localparam int PHT_ENTRY_NUM = 256;
    localparam int HISTORY_WIDTH = 6;
    localparam int QUEUE_SIZE = 4;
    localparam int BTB_ENTRY_NUM = 16;
    localparam int PHT_INDEX_BITS = $clog2(PHT_ENTRY_NUM);
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRY_NUM);
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES = 2000;
    localparam int RUN_CYCLES = PHT_ENTRY_NUM + TEST_CYCLES;
    localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD + 400;
    localparam int POOL_SIZE = 24;
    localparam int RECORD_LIMIT = 32;

    logic clk;
    logic arstN;
    logic fetchValid;
    AddrPath fetchPc;
    logic resValid[ISSUE_WIDTH];
    AddrPath resAddr[ISSUE_WIDTH];
    logic [HISTORY_WIDTH-1:0] resHistory[ISSUE_WIDTH];
    PhtCounter resPhtValue[ISSUE_WIDTH];
    logic resTaken[ISSUE_WIDTH];
    logic resMispred[ISSUE_WIDTH];
    logic resIsCondBr[ISSUE_WIDTH];
    AddrPath resTarget[ISSUE_WIDTH];
    logic btbHit[FETCH_WIDTH];
    AddrPath target[FETCH_WIDTH];
    logic isCondBr[FETCH_WIDTH];
    logic predTaken[FETCH_WIDTH];
    PhtCounter phtValue[FETCH_WIDTH];
    logic [HISTORY_WIDTH-1:0] history;
    logic ready;

    int unsigned lcgState = 32'd61216;
    AddrPath pcPool[POOL_SIZE];
    AddrPath recPc[$];
    logic [HISTORY_WIDTH-1:0] recHist[$];
    PhtCounter recCnt[$];
    int mispredCount = 0;
    logic satHighSeen = 1'b0;
    logic satLowSeen = 1'b0;

    `include "GshareModel.svh"

    BranchPredictor #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .ISSUE_WIDTH(ISSUE_WIDTH),
        .PHT_ENTRY_NUM(PHT_ENTRY_NUM),
        .HISTORY_WIDTH(HISTORY_WIDTH),
        .QUEUE_SIZE(QUEUE_SIZE),
        .BTB_ENTRY_NUM(BTB_ENTRY_NUM)
    ) u_dut (
        .clk(clk),
        .arstN(arstN),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .resValid(resValid),
        .resAddr(resAddr),
        .resHistory(resHistory),
        .resPhtValue(resPhtValue),
        .resTaken(resTaken),
        .resMispred(resMispred),
        .resIsCondBr(resIsCondBr),
        .resTarget(resTarget),
        .btbHit(btbHit),
        .target(target),
        .isCondBr(isCondBr),
        .predTaken(predTaken),
        .phtValue(phtValue),
        .history(history),
        .ready(ready)
    );

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    task automatic failRun(input string msg);
        $display("Error: time %0.1f ns: %s", $realtime, msg);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic checkCounter(input PhtCounter got, input PhtCounter exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic checkAddr(input AddrPath got, input AddrPath exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic checkHistory(input logic [HISTORY_WIDTH-1:0] got,
                                input logic [HISTORY_WIDTH-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("history is %b, expected %b", got, exp));
        end
    endtask

    // Phase 0 mixes the whole pool and later phases train one PC up and then down.
    task automatic driveInputs(input int n);
        int phase;
        int pick;
        phase = (n < RUN_CYCLES - 600) ? 0 : ((n < RUN_CYCLES - 300) ? 1 : 2);
        fetchValid = (nextRand() % 4) != 0;
        fetchPc = (phase == 0) ? pcPool[nextRand() % POOL_SIZE] : pcPool[0];
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            resValid[l] = 1'b0;
            if (mReady && recPc.size() >= FETCH_WIDTH) begin
                if (phase == 0) begin
                    resValid[l] = (nextRand() % 8) < 5;
                    pick = int'(nextRand() % recPc.size());
                    resTaken[l] = (nextRand() % 2) == 1;
                    resMispred[l] = (nextRand() % 8) == 0;
                    resIsCondBr[l] = (nextRand() % 4) != 0;
                end else begin
                    resValid[l] = (l == 0);
                    pick = recPc.size() - FETCH_WIDTH;
                    resTaken[l] = (phase == 1);
                    resMispred[l] = 1'b0;
                    resIsCondBr[l] = 1'b0;
                end
                resAddr[l] = recPc[pick];
                resHistory[l] = recHist[pick];
                resPhtValue[l] = recCnt[pick];
                resTarget[l] = pcPool[nextRand() % POOL_SIZE];
                if (resValid[l] && resMispred[l]) begin
                    mispredCount++;
                end
            end
        end
    endtask

    task automatic checkOutputs();
        checkBit(ready, mReady, "ready");
        checkHistory(history, mHistory);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            checkBit(btbHit[i], mHit[i], $sformatf("btbHit[%0d]", i));
            checkBit(predTaken[i], modelPredTaken(i), $sformatf("predTaken[%0d]", i));
            if (mHit[i]) begin
                checkAddr(target[i], mTarget[i], $sformatf("target[%0d]", i));
                checkBit(isCondBr[i], mCond[i], $sformatf("isCondBr[%0d]", i));
            end
            if (mOutValid) begin
                checkCounter(phtValue[i], mPhtOut[i], $sformatf("phtValue[%0d]", i));
                if (mPhtOut[i] == PHT_COUNTER_MAX) begin
                    satHighSeen = 1'b1;
                end
                if (mPhtOut[i] == 2'd0) begin
                    satLowSeen = 1'b1;
                end
                recPc.push_back(mFetchPc + AddrPath'(i * INSN_BYTE_WIDTH));
                recHist.push_back(mHistory);
                recCnt.push_back(mPhtOut[i]);
            end
        end
        while (recPc.size() > RECORD_LIMIT) begin
            recPc.delete(0);
            recHist.delete(0);
            recCnt.delete(0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        failRun("simulation did not finish");
    end

    initial begin
        arstN = 1'b0;
        fetchValid = 1'b0;
        fetchPc = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            resValid[l] = 1'b0;
            resAddr[l] = '0;
            resHistory[l] = '0;
            resPhtValue[l] = '0;
            resTaken[l] = 1'b0;
            resMispred[l] = 1'b0;
            resIsCondBr[l] = 1'b0;
            resTarget[l] = '0;
        end
        // A small word-aligned range makes BTB sets and PHT entries collide.
        for (int i = 0; i < POOL_SIZE; i++) begin
            pcPool[i] = AddrPath'((nextRand() % 4096) * 4);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        for (int n = 0; n < RUN_CYCLES; n++) begin
            driveInputs(n);
            stepModel();
            @(negedge clk);
            checkOutputs();
        end
        if (dropCount > 0 && mispredCount > 0 && satHighSeen && satLowSeen) begin
            $display("Done: no errors");
            $finish;
        end else begin
            failRun("traffic never hit a queue drop, a misprediction or both saturation limits");
        end
    end

endmodule
